// ==== ncpu_wb_pkg.sv ====
package ncpu_wb_pkg;

   localparam int REG_AW = 5;          // register address width.
   localparam int DW     = 32;         // register value width.
   localparam int PC_W   = 30;         // word pc width.
   localparam int PCB_W  = PC_W + 2;   // byte pc width, word pc times four.

   // one writeback slot as delivered by the execution units.
   typedef struct packed {
      logic              valid;        // slot carries an instruction.
      logic              rd_we;        // instruction writes rd.
      logic [REG_AW-1:0] rd_addr;      // destination register.
      logic [DW-1:0]     dout;         // result value.
      logic [PC_W-1:0]   pc;           // word pc.
   } wb_slot_t;

   // one qualified commit, we already folds in valid and stall.
   typedef struct packed {
      logic              we;           // commit writes the arf.
      logic [REG_AW-1:0] rd_addr;      // destination register.
      logic [DW-1:0]     dout;         // value to write.
      logic [PC_W-1:0]   pc;           // word pc.
   } commit_t;

   // one record on the trace port.
   typedef struct packed {
      logic [PCB_W-1:0]  pc_byte;      // byte pc.
      logic [REG_AW-1:0] rd_addr;      // destination register.
      logic [DW-1:0]     dout;         // written value.
   } trace_rec_t;

endpackage

// ==== wb_slot_capture.sv ====
module wb_slot_capture
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  stall_bck,   // backend stall, drops the sampled pair.
   input  ncpu_wb_pkg::wb_slot_t slot_1,      // older slot.
   input  ncpu_wb_pkg::wb_slot_t slot_2,      // younger slot.
   output ncpu_wb_pkg::commit_t  commit_1,    // registered commit of slot 1.
   output ncpu_wb_pkg::commit_t  commit_2     // registered commit of slot 2.
);
   import ncpu_wb_pkg::*;

   wb_slot_t [1:0]              slot_in;      // index 0 is slot 1.
   logic     [1:0]              we_d;         // qualified write enables.
   logic     [1:0]              we_q;         // registered write enables.
   logic     [1:0][REG_AW-1:0]  rd_addr_q;    // sampled destinations.
   logic     [1:0][DW-1:0]      dout_q;       // sampled results.
   logic     [1:0][PC_W-1:0]    pc_q;         // sampled word pcs.

   assign slot_in = {slot_2, slot_1};         // keep program order in the index.

   // a slot commits only if valid, writing and not stalled.
   always_comb
   begin
      for (int s = 0; s < 2; s++)
         we_d[s] = slot_in[s].valid & slot_in[s].rd_we & ~stall_bck;
   end

   // control bits, cleared by reset.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         we_q <= '0;                          // no commit out of reset.
      else
         we_q <= we_d;
   end

   // payload is sampled every edge, meaningful only with we set.
   always_ff @(posedge clk)
   begin
      for (int s = 0; s < 2; s++)
      begin
         rd_addr_q[s] <= slot_in[s].rd_addr;
         dout_q[s]    <= slot_in[s].dout;
         pc_q[s]      <= slot_in[s].pc;
      end
   end

   always_comb
   begin
      commit_1 = '{we: we_q[0], rd_addr: rd_addr_q[0], dout: dout_q[0], pc: pc_q[0]};
      commit_2 = '{we: we_q[1], rd_addr: rd_addr_q[1], dout: dout_q[1], pc: pc_q[1]};
   end

   // an unknown valid would leak X into the arf and the trace fifo.
   a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown({slot_1.valid, slot_2.valid}))
      else $error("wb_slot_capture: unknown slot valid");

endmodule

// ==== arf_2w.sv ====
module arf_2w
#(
   parameter int NREGS = 32                            // architectural registers.
)
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  ncpu_wb_pkg::commit_t           commit_1,    // write port 1.
   input  ncpu_wb_pkg::commit_t           commit_2,    // write port 2, wins on a tie.
   input  logic [ncpu_wb_pkg::REG_AW-1:0] rs1_addr,    // read port 1 address.
   input  logic [ncpu_wb_pkg::REG_AW-1:0] rs2_addr,    // read port 2 address.
   output logic [ncpu_wb_pkg::DW-1:0]     rs1_data,    // read port 1 data.
   output logic [ncpu_wb_pkg::DW-1:0]     rs2_data     // read port 2 data.
);
   import ncpu_wb_pkg::*;

   // r0 has no storage, the array starts at r1.
   logic [DW-1:0] regs [1:NREGS-1];

   // hit on a storable register, r0 and out-of-range addresses miss.
   function automatic logic hit(input logic [REG_AW-1:0] addr, input int idx);
      hit = (int'(addr) == idx);
   endfunction

   // combinational read, zero for r0 and unmapped addresses.
   function automatic logic [DW-1:0] read_reg(input logic [REG_AW-1:0] addr);
      read_reg = '0;
      if (addr != '0 && int'(addr) < NREGS)
         read_reg = regs[addr];
   endfunction

   // both ports write the same edge, port 2 is checked first.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 1; i < NREGS; i++)
            regs[i] <= '0;                             // all registers read zero.
      end
      else
      begin
         for (int i = 1; i < NREGS; i++)
         begin
            if (commit_2.we && hit(commit_2.rd_addr, i))
               regs[i] <= commit_2.dout;               // younger write kept.
            else if (commit_1.we && hit(commit_1.rd_addr, i))
               regs[i] <= commit_1.dout;
         end
      end
   end

   // read ports see a write right after its edge.
   always_comb
   begin
      rs1_data = read_reg(rs1_addr);
      rs2_data = read_reg(rs2_addr);
   end

   // slot 2 must survive any same-address write from slot 1.
   a_slot2_wins: assert property (@(posedge clk) disable iff (!rst_n)
      (commit_2.we && commit_2.rd_addr != '0 && int'(commit_2.rd_addr) < NREGS)
      |=> read_reg($past(commit_2.rd_addr)) == $past(commit_2.dout))
      else $error("arf_2w: slot 2 write lost");

endmodule

// ==== commit_tracer.sv ====
module commit_tracer
#(
   parameter int TRACE_DEPTH = 8                       // fifo depth, power of two.
)
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  ncpu_wb_pkg::commit_t    commit_1,           // older commit.
   input  ncpu_wb_pkg::commit_t    commit_2,           // younger commit.
   output logic                    trace_valid,        // one strobe per record.
   output ncpu_wb_pkg::trace_rec_t trace_rec,          // valid with trace_valid.
   output logic                    trace_overflow      // sticky, a record was dropped.
);
   import ncpu_wb_pkg::*;

   localparam int PTR_W = $clog2(TRACE_DEPTH);         // pointer width.
   localparam int CNT_W = $clog2(TRACE_DEPTH + 1);     // fill count width.

   trace_rec_t       fifo_mem [TRACE_DEPTH];           // circular record buffer.
   logic [PTR_W-1:0] wr_ptr_q;                         // next free slot.
   logic [PTR_W-1:0] wr_ptr_2;                         // slot for the second record.
   logic [PTR_W-1:0] rd_ptr_q;                         // oldest record.
   logic [CNT_W-1:0] count_q;                          // records held.
   logic [CNT_W-1:0] count_1;                          // fill after the first push.
   logic             acc_1;                            // commit 1 record accepted.
   logic             acc_2;                            // commit 2 record accepted.
   logic             drop;                             // a record found the fifo full.
   logic             pop;                              // move head to the output.

   // byte pc is the word pc shifted left by two.
   function automatic trace_rec_t make_rec(input commit_t c);
      make_rec.pc_byte = {c.pc, 2'b00};
      make_rec.rd_addr = c.rd_addr;
      make_rec.dout    = c.dout;
   endfunction

   // pushes see the fill before this edge's pop.
   always_comb
   begin
      acc_1    = commit_1.we && (int'(count_q) < TRACE_DEPTH);
      count_1  = count_q + CNT_W'(acc_1);
      acc_2    = commit_2.we && (int'(count_1) < TRACE_DEPTH);
      drop     = (commit_1.we && !acc_1) || (commit_2.we && !acc_2);
      wr_ptr_2 = wr_ptr_q + PTR_W'(acc_1);             // behind record 1 if it went in.
      pop      = (count_q != '0);
   end

   // pointers, count and flags.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr_q       <= '0;
         rd_ptr_q       <= '0;
         count_q        <= '0;                         // fifo empty.
         trace_valid    <= 1'b0;
         trace_overflow <= 1'b0;
      end
      else
      begin
         wr_ptr_q    <= wr_ptr_2 + PTR_W'(acc_2);
         rd_ptr_q    <= rd_ptr_q + PTR_W'(pop);
         count_q     <= count_1 + CNT_W'(acc_2) - CNT_W'(pop);
         trace_valid <= pop;                           // registered strobe.
         if (drop)
            trace_overflow <= 1'b1;                    // held until reset.
      end
   end

   // storage and output record, no reset needed on data.
   always_ff @(posedge clk)
   begin
      if (acc_1)
         fifo_mem[wr_ptr_q] <= make_rec(commit_1);
      if (acc_2)
         fifo_mem[wr_ptr_2] <= make_rec(commit_2);
      if (pop)
         trace_rec <= fifo_mem[rd_ptr_q];              // head slot is never written here.
   end

   // fill count bounded by the depth.
   a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
      int'(count_q) <= TRACE_DEPTH)
      else $error("commit_tracer: fill count above depth");

   // a strobe needs the pointers to show a record the cycle before.
   a_no_empty_pop: assert property (@(posedge clk) disable iff (!rst_n)
      trace_valid |-> $past(wr_ptr_q != rd_ptr_q || int'(count_q) == TRACE_DEPTH))
      else $error("commit_tracer: trace_valid from an empty fifo");

endmodule

// ==== ncpu_wb_top.sv ====
module ncpu_wb_top
#(
   parameter int NREGS       = 32,                     // architectural registers.
   parameter int TRACE_DEPTH = 8                       // trace fifo depth.
)
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           stall_bck,      // backend stall.
   input  ncpu_wb_pkg::wb_slot_t          slot_1,         // writeback slot 1.
   input  ncpu_wb_pkg::wb_slot_t          slot_2,         // writeback slot 2.
   input  logic [ncpu_wb_pkg::REG_AW-1:0] rs1_addr,       // read port 1 address.
   input  logic [ncpu_wb_pkg::REG_AW-1:0] rs2_addr,       // read port 2 address.
   output logic [ncpu_wb_pkg::DW-1:0]     rs1_data,       // read port 1 data.
   output logic [ncpu_wb_pkg::DW-1:0]     rs2_data,       // read port 2 data.
   output logic                           trace_valid,    // trace strobe.
   output ncpu_wb_pkg::trace_rec_t        trace_rec,      // trace record.
   output logic                           trace_overflow  // sticky drop flag.
);
   import ncpu_wb_pkg::*;

   commit_t commit_1;                                  // qualified slot 1.
   commit_t commit_2;                                  // qualified slot 2.

   // sample slots, fold stall into we.
   wb_slot_capture u_capture
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .stall_bck (stall_bck),
      .slot_1    (slot_1),
      .slot_2    (slot_2),
      .commit_1  (commit_1),
      .commit_2  (commit_2)
   );

   // architectural state.
   arf_2w
   #(
      .NREGS (NREGS)
   )
   u_arf
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .commit_1 (commit_1),
      .commit_2 (commit_2),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   // ordered trace of every commit.
   commit_tracer
   #(
      .TRACE_DEPTH (TRACE_DEPTH)
   )
   u_tracer
   (
      .clk            (clk),
      .rst_n          (rst_n),
      .commit_1       (commit_1),
      .commit_2       (commit_2),
      .trace_valid    (trace_valid),
      .trace_rec      (trace_rec),
      .trace_overflow (trace_overflow)
   );

endmodule

// ==== tb_ncpu_wb.sv ====
module tb_ncpu_wb;
   timeunit 1ns;
   timeprecision 1ps;
   import ncpu_wb_pkg::*;

   localparam int NREGS       = 32;                  // dut default.
   localparam int TRACE_DEPTH = 8;                   // dut default.
   localparam int CLK_PERIOD  = 40;
   localparam int IDLE_N      = 10;                  // drain cycles after a burst.
   localparam int SWEEP_N     = NREGS + 1;           // read sweep length.
   localparam int RAND_N      = 400;
   localparam int OVF_N       = 10;
   localparam int CHK_W       = $bits(trace_rec_t);  // widest compared value.
   // four directed blocks of at most three pairs, then random and overflow.
   localparam int STIM_CYCLES = 2 + 4 * (3 + IDLE_N + SWEEP_N)
                              + RAND_N + 2 * IDLE_N + SWEEP_N + OVF_N + 3 * IDLE_N;
   localparam int WATCHDOG_NS = (STIM_CYCLES + 50) * CLK_PERIOD;
   localparam wb_slot_t NO_SLOT = '0;

   logic                clk;
   logic                rst_n;
   logic                stall_bck;
   wb_slot_t            slot_1;
   wb_slot_t            slot_2;
   logic [REG_AW-1:0]   rs1_addr;
   logic [REG_AW-1:0]   rs2_addr;
   logic [DW-1:0]       rs1_data;
   logic [DW-1:0]       rs2_data;
   logic                trace_valid;
   trace_rec_t          trace_rec;
   logic                trace_overflow;

   logic [DW-1:0]       model_regs [NREGS];          // reference register file.
   trace_rec_t          exp_q [$];                   // records the dut should emit.
   trace_rec_t          pend [2];                    // records sampled one edge ago.
   int                  pend_n;
   int                  model_fill;                  // reference fifo fill.
   bit                  model_pop;
   bit                  exp_ovf;                     // predicted overflow flag.
   trace_rec_t          exp_head;

   ncpu_wb_top u_dut
   (
      .clk            (clk),
      .rst_n          (rst_n),
      .stall_bck      (stall_bck),
      .slot_1         (slot_1),
      .slot_2         (slot_2),
      .rs1_addr       (rs1_addr),
      .rs2_addr       (rs2_addr),
      .rs1_data       (rs1_data),
      .rs2_data       (rs2_data),
      .trace_valid    (trace_valid),
      .trace_rec      (trace_rec),
      .trace_overflow (trace_overflow)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string sig, input logic [CHK_W-1:0] expv,
                                  input logic [CHK_W-1:0] gotv);
      stop_run($sformatf("Error at %0t ns: %s expected 0x%0h got 0x%0h",
                         $time, sig, expv, gotv));
   endtask

   function automatic wb_slot_t make_slot(input logic v, input logic we, input int rd,
                                          input logic [DW-1:0] d, input logic [PC_W-1:0] pc);
      wb_slot_t s;
      s.valid   = v;
      s.rd_we   = we;
      s.rd_addr = REG_AW'(rd);
      s.dout    = d;
      s.pc      = pc;
      return s;
   endfunction

   function automatic wb_slot_t random_slot();
      wb_slot_t s;
      s.valid   = 1'($urandom % 2);                  // about half valid.
      s.rd_we   = 1'($urandom % 2);
      s.rd_addr = REG_AW'($urandom);
      s.dout    = $urandom;
      s.pc      = PC_W'($urandom);
      return s;
   endfunction

   // applies one sampled pair, returns how many records it yields, in order.
   function automatic int model_pair(input logic stall, input wb_slot_t s1, input wb_slot_t s2,
                                     output trace_rec_t r1, output trace_rec_t r2);
      int         n;
      wb_slot_t   s [2];
      trace_rec_t r [2];
      n    = 0;
      s[0] = s1;
      s[1] = s2;
      r[0] = '0;
      r[1] = '0;
      for (int i = 0; i < 2; i++)
      begin
         if (!stall && s[i].valid && s[i].rd_we)
         begin
            r[n].pc_byte = 32'(s[i].pc) * 32'd4;    // byte pc.
            r[n].rd_addr = s[i].rd_addr;
            r[n].dout    = s[i].dout;
            if (s[i].rd_addr != '0)
               model_regs[s[i].rd_addr] = s[i].dout; // slot 2 last, so it wins.
            n++;
         end
      end
      r1 = r[0];
      r2 = r[1];
      return n;
   endfunction

   // reference fifo, push at the edge after sampling, pop decided on old fill.
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NREGS; i++)
            model_regs[i] = '0;
         exp_q.delete();
         pend_n     = 0;
         model_fill = 0;
         exp_ovf    = 1'b0;
      end
      else
      begin
         model_pop = (model_fill != 0);
         for (int j = 0; j < pend_n; j++)
         begin
            if (model_fill < TRACE_DEPTH)
            begin
               exp_q.push_back(pend[j]);
               model_fill++;
            end
            else
               exp_ovf = 1'b1;                       // record dropped.
         end
         if (model_pop)
            model_fill--;
         pend_n = model_pair(stall_bck, slot_1, slot_2, pend[0], pend[1]);
      end
   end

   // trace port compare, outputs settled by the falling edge.
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         assert (trace_overflow == exp_ovf)
            else report_mismatch("trace_overflow", CHK_W'(exp_ovf), CHK_W'(trace_overflow));
         if (trace_valid)
         begin
            assert (exp_q.size() != 0)
               else stop_run("trace_valid was high with no record expected");
            exp_head = exp_q.pop_front();
            assert (trace_rec == exp_head)
               else report_mismatch("trace_rec", exp_head, trace_rec);
         end
      end
   end

   task automatic drive_pair(input logic stall, input wb_slot_t s1, input wb_slot_t s2);
      @(negedge clk);
      stall_bck = stall;
      slot_1    = s1;
      slot_2    = s2;
   endtask

   task automatic run_idle(input int n);
      repeat (n) drive_pair(1'b0, NO_SLOT, NO_SLOT);
   endtask

   task automatic expect_drained();
      assert (exp_q.size() == 0)
         else stop_run("expected trace records never came out");
   endtask

   // rs1 walks up, rs2 walks down, each checked one cycle later.
   task automatic sweep_regs();
      for (int i = 0; i <= NREGS; i++)
      begin
         @(negedge clk);
         if (i > 0)
         begin
            assert (rs1_data == model_regs[i - 1])
               else report_mismatch("rs1_data", CHK_W'(model_regs[i - 1]), CHK_W'(rs1_data));
            assert (rs2_data == model_regs[NREGS - i])
               else report_mismatch("rs2_data", CHK_W'(model_regs[NREGS - i]),
                                    CHK_W'(rs2_data));
         end
         if (i < NREGS)
         begin
            rs1_addr = REG_AW'(i);
            rs2_addr = REG_AW'(NREGS - 1 - i);
         end
      end
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      stop_run("watchdog expired before the tests finished");
   end

   initial
   begin
      void'($urandom(32'hb75d7ce6));                 // one seed for the run.
      rst_n     = 1'b0;
      stall_bck = 1'b0;
      slot_1    = NO_SLOT;
      slot_2    = NO_SLOT;
      rs1_addr  = '0;
      rs2_addr  = '0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      // single slot commits.
      drive_pair(1'b0, make_slot(1, 1, 5, 32'h1111_0005, 30'h100), NO_SLOT);
      drive_pair(1'b0, NO_SLOT, make_slot(1, 1, 6, 32'h2222_0006, 30'h101));
      run_idle(IDLE_N);
      expect_drained();
      sweep_regs();

      // dual commits, distinct then same register.
      drive_pair(1'b0, make_slot(1, 1, 7, 32'h3333_0007, 30'h200),
                 make_slot(1, 1, 8, 32'h4444_0008, 30'h201));
      drive_pair(1'b0, make_slot(1, 1, 9, 32'haaaa_0009, 30'h202),
                 make_slot(1, 1, 9, 32'hbbbb_0009, 30'h203));
      run_idle(IDLE_N);
      expect_drained();
      sweep_regs();

      // stalled and disabled pairs leave no trace.
      drive_pair(1'b1, make_slot(1, 1, 5, 32'hdead_0005, 30'h300),
                 make_slot(1, 1, 6, 32'hdead_0006, 30'h301));
      drive_pair(1'b0, make_slot(0, 1, 7, 32'hdead_0007, 30'h302),
                 make_slot(1, 0, 8, 32'hdead_0008, 30'h303));
      drive_pair(1'b0, make_slot(1, 0, 9, 32'hdead_0009, 30'h304),
                 make_slot(0, 0, 10, 32'hdead_000a, 30'h305));
      run_idle(IDLE_N);
      expect_drained();
      sweep_regs();

      // r0 is traced but never written.
      drive_pair(1'b0, make_slot(1, 1, 0, 32'hcafe_0000, 30'h400),
                 make_slot(1, 1, 0, 32'hcafe_0001, 30'h401));
      drive_pair(1'b0, make_slot(1, 1, 0, 32'hcafe_0002, 30'h402),
                 make_slot(1, 1, 10, 32'h5555_000a, 30'h403));
      run_idle(IDLE_N);
      expect_drained();
      sweep_regs();

      // random traffic.
      repeat (RAND_N) drive_pair(1'($urandom % 2), random_slot(), random_slot());
      run_idle(2 * IDLE_N);
      expect_drained();
      assert (!trace_overflow)
         else report_mismatch("trace_overflow", CHK_W'(0), CHK_W'(trace_overflow));
      sweep_regs();

      // back to back dual commits overrun the fifo.
      for (int c = 0; c < OVF_N; c++)
         drive_pair(1'b0, make_slot(1, 1, 11 + c, 32'h6000_0000 + c, PC_W'(30'h500 + 2 * c)),
                    make_slot(1, 1, 21 + c % 10, 32'h7000_0000 + c, PC_W'(30'h501 + 2 * c)));
      run_idle(3 * IDLE_N);
      assert (trace_overflow)
         else report_mismatch("trace_overflow", CHK_W'(1), CHK_W'(trace_overflow));

      assert (exp_q.size() == 0 && model_fill == 0)
         else stop_run("trace records still expected at the end of the run");
      $display("All checks passed");
      $finish;
   end

endmodule

// ==== src.f ====
ncpu_wb_pkg.sv
wb_slot_capture.sv
arf_2w.sv
commit_tracer.sv
ncpu_wb_top.sv
tb_ncpu_wb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator and run, the exit status carries pass or fail.
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -j 0 -f src.f --top-module tb_ncpu_wb \
   -Mdir obj_dir -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "simulation failed"; exit 1; }
